// File: verilog/meminit_pkg.sv
// boot memory initializer shared definitions
// memory command, boot phase, image stream and cpu request types
package meminit_pkg;

    typedef logic [31:0] word_t;

    localparam word_t      WORD_BYTES = 32'd4;  // byte step between words
    localparam logic [3:0] BE_ALL     = 4'b1111;

    // memory opcodes
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

    // one memory access, held by the requester until busy is seen high
    typedef struct packed {
        mem_op_e    op;
        word_t      addr;   // byte address
        word_t      wdata;
        logic [3:0] be;
    } mem_cmd_t;

    localparam mem_cmd_t CMD_IDLE = '{op: OP_IDLE, addr: '0, wdata: '0, be: '0};

    typedef enum logic [2:0] {
        PH_CALIB  = 3'd0,  // dram controller still calibrating
        PH_ZERO   = 3'd1,
        PH_LOAD   = 3'd2,
        PH_VERIFY = 3'd3,
        PH_RUN    = 3'd4   // cpu owns the port
    } boot_phase_e;

    // image word stream, paired with a ready from the loader
    typedef struct packed {
        logic  valid;
        word_t data;
    } img_word_t;

    // cpu side request, same busy rule as the memory port
    typedef struct packed {
        logic       rd;
        logic       wr;
        word_t      addr;
        word_t      wdata;
        logic [3:0] be;
    } cpu_req_t;

endpackage

// File: verilog/boot_sequencer.sv
// boot phase sequencer
// steps calib, zero fill, image load, readback verify and run in order,
// one step per done level, never going back until reset
`timescale 1ns/1ns

module boot_sequencer import meminit_pkg::*; (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_calib_done,
    input  logic        i_zero_done,
    input  logic        i_load_done,
    input  logic        i_verify_done,
    output boot_phase_e o_phase
);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_phase <= PH_CALIB;
        end else begin
            case (o_phase)
                PH_CALIB: begin
                    if (i_calib_done) begin
                        o_phase <= PH_ZERO;
                    end
                end
                PH_ZERO: begin
                    if (i_zero_done) begin
                        o_phase <= PH_LOAD;
                    end
                end
                PH_LOAD: begin
                    if (i_load_done) begin
                        o_phase <= PH_VERIFY;
                    end
                end
                PH_VERIFY: begin
                    if (i_verify_done) begin
                        o_phase <= PH_RUN;
                    end
                end
                PH_RUN: begin
                    o_phase <= PH_RUN;  // final phase, stays here
                end
                default: begin
                    o_phase <= PH_CALIB;
                end
            endcase
        end
    end

endmodule

// File: verilog/zero_fill.sv
// zero filler
// writes zero words to consecutive addresses from 0 during PH_ZERO
`timescale 1ns/1ns

module zero_fill import meminit_pkg::*; #(
    parameter int ZERO_WORDS = 256
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  boot_phase_e i_phase,
    input  logic        i_busy,
    output mem_cmd_t    o_cmd,
    output logic        o_done
);

    localparam int              CNT_W = $clog2(ZERO_WORDS + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(ZERO_WORDS - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,  // write held until busy seen high
        S_WAIT,   // access in flight
        S_DONE
    } state_e;

    state_e           r_state;
    logic [CNT_W-1:0] r_idx;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_state <= S_IDLE;
            r_idx   <= '0;
        end else begin
            case (r_state)
                S_IDLE: begin
                    if (i_phase == PH_ZERO && !i_busy) begin
                        r_state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (i_busy) begin
                        r_state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (!i_busy) begin
                        if (r_idx == LAST) begin
                            r_state <= S_DONE;
                        end else begin
                            r_idx   <= r_idx + 1'b1;
                            r_state <= S_ISSUE;  // busy is low, go straight on
                        end
                    end
                end
                default: r_state <= S_DONE;
            endcase
        end
    end

    always_comb begin
        o_cmd = CMD_IDLE;
        if (r_state == S_ISSUE) begin
            o_cmd.op    = OP_WRITE;
            o_cmd.addr  = word_t'(r_idx) * WORD_BYTES;
            o_cmd.wdata = '0;
            o_cmd.be    = BE_ALL;
        end
    end

    assign o_done = (r_state == S_DONE);

endmodule

// File: verilog/image_loader.sv
// image loader
// accepts image words from the stream, writes them from IMG_BASE upward
// and keeps a running 32-bit sum of the words as the load checksum
`timescale 1ns/1ns

module image_loader import meminit_pkg::*; #(
    parameter word_t IMG_BASE  = 32'h0000_0400,
    parameter int    IMG_WORDS = 64
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  boot_phase_e i_phase,
    input  img_word_t   i_img,
    input  logic        i_busy,
    output logic        o_img_ready,
    output mem_cmd_t    o_cmd,
    output word_t       o_checksum,
    output logic        o_done
);

    localparam int              CNT_W = $clog2(IMG_WORDS + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(IMG_WORDS - 1);

    typedef enum logic [1:0] {
        S_IDLE,   // holding no word, ready in PH_LOAD
        S_ISSUE,
        S_WAIT,
        S_DONE
    } state_e;

    state_e           r_state;
    logic [CNT_W-1:0] r_idx;
    word_t            r_data;     // captured stream word
    word_t            r_checksum;
    logic             w_take;

    assign o_img_ready = (i_phase == PH_LOAD) && (r_state == S_IDLE);
    assign w_take      = o_img_ready && i_img.valid;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_state    <= S_IDLE;
            r_idx      <= '0;
            r_checksum <= '0;
        end else begin
            case (r_state)
                S_IDLE: begin
                    if (w_take) begin
                        r_checksum <= r_checksum + i_img.data;  // wraps mod 2^32
                        r_state    <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (i_busy) begin
                        r_state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (!i_busy) begin
                        if (r_idx == LAST) begin
                            r_state <= S_DONE;
                        end else begin
                            r_idx   <= r_idx + 1'b1;
                            r_state <= S_IDLE;
                        end
                    end
                end
                default: r_state <= S_DONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (w_take) begin
            r_data <= i_img.data;
        end
    end

    always_comb begin
        o_cmd = CMD_IDLE;
        if (r_state == S_ISSUE) begin
            o_cmd.op    = OP_WRITE;
            o_cmd.addr  = IMG_BASE + word_t'(r_idx) * WORD_BYTES;
            o_cmd.wdata = r_data;
            o_cmd.be    = BE_ALL;
        end
    end

    assign o_checksum = r_checksum;
    assign o_done     = (r_state == S_DONE);

endmodule

// File: verilog/readback_verify.sv
// readback verifier
// reads the loaded image back in load order, sums the read data and
// flags a match against the load checksum before reporting done
`timescale 1ns/1ns

module readback_verify import meminit_pkg::*; #(
    parameter word_t IMG_BASE  = 32'h0000_0400,
    parameter int    IMG_WORDS = 64
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  boot_phase_e i_phase,
    input  logic        i_busy,
    input  word_t       i_rdata,
    input  word_t       i_load_checksum,
    output mem_cmd_t    o_cmd,
    output logic        o_done,
    output logic        o_match
);

    localparam int              CNT_W = $clog2(IMG_WORDS + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(IMG_WORDS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,   // read data comes with the falling busy
        S_CHECK,
        S_DONE
    } state_e;

    state_e           r_state;
    logic [CNT_W-1:0] r_idx;
    word_t            r_sum;
    logic             r_match;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_state <= S_IDLE;
            r_idx   <= '0;
            r_sum   <= '0;
            r_match <= 1'b0;
        end else begin
            case (r_state)
                S_IDLE: begin
                    if (i_phase == PH_VERIFY && !i_busy) begin
                        r_state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (i_busy) begin
                        r_state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (!i_busy) begin
                        r_sum <= r_sum + i_rdata;
                        if (r_idx == LAST) begin
                            r_state <= S_CHECK;
                        end else begin
                            r_idx   <= r_idx + 1'b1;
                            r_state <= S_ISSUE;
                        end
                    end
                end
                S_CHECK: begin
                    r_match <= (r_sum == i_load_checksum);  // sum is final here
                    r_state <= S_DONE;
                end
                default: r_state <= S_DONE;
            endcase
        end
    end

    always_comb begin
        o_cmd = CMD_IDLE;
        if (r_state == S_ISSUE) begin
            o_cmd.op   = OP_READ;
            o_cmd.addr = IMG_BASE + word_t'(r_idx) * WORD_BYTES;
            o_cmd.be   = BE_ALL;
        end
    end

    assign o_done  = (r_state == S_DONE);
    assign o_match = r_match;

endmodule

// File: verilog/mem_arbiter.sv
// memory port arbiter
// forwards the command of the peer owning the current phase, latches cpu
// requests in PH_RUN and routes busy so that every non-owner sees it high
`timescale 1ns/1ns

module mem_arbiter import meminit_pkg::*; #(
    parameter word_t ADDR_MASK = 32'h03FF_FFFF
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  boot_phase_e i_phase,
    input  mem_cmd_t    i_zero_cmd,
    input  mem_cmd_t    i_load_cmd,
    input  mem_cmd_t    i_verify_cmd,
    input  cpu_req_t    i_cpu,
    input  logic        i_mem_busy,
    input  word_t       i_mem_rdata,
    output mem_cmd_t    o_mem_cmd,
    output logic        o_zero_busy,
    output logic        o_load_busy,
    output logic        o_verify_busy,
    output logic        o_cpu_busy,
    output word_t       o_cpu_rdata
);

    logic     r_cpu_held;  // cpu command presented, memory not yet busy
    mem_cmd_t r_cpu_cmd;
    logic     w_run;
    logic     w_cpu_req;

    assign w_run     = (i_phase == PH_RUN);
    assign w_cpu_req = i_cpu.rd | i_cpu.wr;

    // held flag gives the cpu request the same handshake as the boot peers
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_cpu_held <= 1'b0;
        end else if (r_cpu_held) begin
            if (i_mem_busy) begin
                r_cpu_held <= 1'b0;  // memory has taken it
            end
        end else if (w_run && w_cpu_req && !i_mem_busy) begin
            r_cpu_held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!r_cpu_held) begin
            r_cpu_cmd.op    <= i_cpu.wr ? OP_WRITE : OP_READ;  // write wins
            r_cpu_cmd.addr  <= i_cpu.addr & ADDR_MASK;
            r_cpu_cmd.wdata <= i_cpu.wdata;
            r_cpu_cmd.be    <= i_cpu.be;
        end
    end

    always_comb begin
        case (i_phase)
            PH_ZERO:   o_mem_cmd = i_zero_cmd;
            PH_LOAD:   o_mem_cmd = i_load_cmd;
            PH_VERIFY: o_mem_cmd = i_verify_cmd;
            PH_RUN:    o_mem_cmd = r_cpu_held ? r_cpu_cmd : CMD_IDLE;
            default:   o_mem_cmd = CMD_IDLE;
        endcase
        if (!w_run) begin
            o_mem_cmd.be = BE_ALL;  // full words during boot
        end
    end

    // non-owners see busy high
    assign o_zero_busy   = (i_phase == PH_ZERO) ? i_mem_busy : 1'b1;
    assign o_load_busy   = (i_phase == PH_LOAD) ? i_mem_busy : 1'b1;
    assign o_verify_busy = (i_phase == PH_VERIFY) ? i_mem_busy : 1'b1;
    assign o_cpu_busy    = w_run ? (r_cpu_held | i_mem_busy) : 1'b1;
    assign o_cpu_rdata   = w_run ? i_mem_rdata : '0;

endmodule

// File: verilog/mem_boot_top.sv
// boot memory initializer top level
// phase sequencer, zero filler, image loader, readback verifier and the
// arbiter sharing one external memory port
`timescale 1ns/1ns

module mem_boot_top import meminit_pkg::*; #(
    parameter int    ZERO_WORDS = 256,
    parameter word_t IMG_BASE   = 32'h0000_0400,
    parameter int    IMG_WORDS  = 64,
    parameter word_t ADDR_MASK  = 32'h03FF_FFFF
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_calib_done,
    input  img_word_t   i_img,
    input  cpu_req_t    i_cpu,
    input  logic        i_mem_busy,
    input  word_t       i_mem_rdata,
    output logic        o_img_ready,
    output logic        o_cpu_busy,
    output word_t       o_cpu_rdata,
    output mem_cmd_t    o_mem_cmd,
    output boot_phase_e o_phase,
    output logic        o_boot_done,
    output logic        o_verify_ok,
    output word_t       o_load_checksum
);

    logic     w_zero_done, w_load_done, w_verify_done;
    logic     w_zero_busy, w_load_busy, w_verify_busy;
    mem_cmd_t w_zero_cmd, w_load_cmd, w_verify_cmd;

    assign o_boot_done = (o_phase == PH_RUN);

    boot_sequencer u_seq (
        .clk(clk), .i_arst_n(i_arst_n), .i_calib_done(i_calib_done),
        .i_zero_done(w_zero_done), .i_load_done(w_load_done),
        .i_verify_done(w_verify_done), .o_phase(o_phase)
    );

    zero_fill #(.ZERO_WORDS(ZERO_WORDS)) u_zero (
        .clk(clk), .i_arst_n(i_arst_n), .i_phase(o_phase), .i_busy(w_zero_busy),
        .o_cmd(w_zero_cmd), .o_done(w_zero_done)
    );

    image_loader #(.IMG_BASE(IMG_BASE), .IMG_WORDS(IMG_WORDS)) u_load (
        .clk(clk), .i_arst_n(i_arst_n), .i_phase(o_phase), .i_img(i_img),
        .i_busy(w_load_busy), .o_img_ready(o_img_ready), .o_cmd(w_load_cmd),
        .o_checksum(o_load_checksum), .o_done(w_load_done)
    );

    readback_verify #(.IMG_BASE(IMG_BASE), .IMG_WORDS(IMG_WORDS)) u_verify (
        .clk(clk), .i_arst_n(i_arst_n), .i_phase(o_phase), .i_busy(w_verify_busy),
        .i_rdata(i_mem_rdata), .i_load_checksum(o_load_checksum),
        .o_cmd(w_verify_cmd), .o_done(w_verify_done), .o_match(o_verify_ok)
    );

    mem_arbiter #(.ADDR_MASK(ADDR_MASK)) u_arb (
        .clk(clk), .i_arst_n(i_arst_n), .i_phase(o_phase),
        .i_zero_cmd(w_zero_cmd), .i_load_cmd(w_load_cmd), .i_verify_cmd(w_verify_cmd),
        .i_cpu(i_cpu), .i_mem_busy(i_mem_busy), .i_mem_rdata(i_mem_rdata),
        .o_mem_cmd(o_mem_cmd), .o_zero_busy(w_zero_busy), .o_load_busy(w_load_busy),
        .o_verify_busy(w_verify_busy), .o_cpu_busy(o_cpu_busy), .o_cpu_rdata(o_cpu_rdata)
    );

endmodule

// File: bench/mem_boot_checker.sv
// memory port protocol checker
// bound into the arbiter, watches the peer commands and the command it forwards
`timescale 1ns/1ns

module mem_boot_checker import meminit_pkg::*; (
    input logic        clk,
    input logic        i_arst_n,
    input boot_phase_e i_phase,
    input mem_cmd_t    i_zero_cmd,
    input mem_cmd_t    i_load_cmd,
    input mem_cmd_t    i_verify_cmd,
    input logic        i_mem_busy,
    input mem_cmd_t    o_mem_cmd,
    input logic        r_cpu_held
);

    // no peer asks for the memory while the dram controller calibrates
    a_calib_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_phase == PH_CALIB) |-> (i_zero_cmd.op == OP_IDLE && i_load_cmd.op == OP_IDLE
                                   && i_verify_cmd.op == OP_IDLE))
    else $error("memory command issued during calibration");

    // held until busy seen high
    a_cmd_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_mem_cmd.op != OP_IDLE && !i_mem_busy) |=> $stable(o_mem_cmd))
    else $error("held memory command changed before busy was seen");

    a_cpu_run_only: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_phase != PH_RUN) |-> !r_cpu_held)
    else $error("cpu command held before the run phase");

endmodule

bind mem_arbiter mem_boot_checker u_checker (
    .clk(clk),
    .i_arst_n(i_arst_n),
    .i_phase(i_phase),
    .i_zero_cmd(i_zero_cmd),
    .i_load_cmd(i_load_cmd),
    .i_verify_cmd(i_verify_cmd),
    .i_mem_busy(i_mem_busy),
    .o_mem_cmd(o_mem_cmd),
    .r_cpu_held(r_cpu_held)
);

// File: bench/tb_mem_boot.sv
// boot memory initializer testbench
// models the external memory with random latency, streams the image words
// and runs the cpu accesses listed in the stimulus file
`timescale 1ns/1ns

module tb_mem_boot import meminit_pkg::*; ();

    localparam int    ZERO_WORDS   = 16;
    localparam word_t IMG_BASE     = 32'h20;
    localparam int    IMG_WORDS    = 8;
    localparam word_t ADDR_MASK    = 32'hFF;
    localparam int    TIMEOUT      = 2000;  // cycles per wait
    localparam int    SIG_READY    = 0;
    localparam int    SIG_DONE     = 1;
    localparam int    SIG_CPU_BUSY = 2;

    logic        clk;
    logic        i_arst_n;
    logic        i_calib_done;
    img_word_t   i_img;
    cpu_req_t    i_cpu;
    logic        mem_busy;
    word_t       mem_rdata;
    logic        o_img_ready, o_cpu_busy, o_boot_done, o_verify_ok;
    word_t       o_cpu_rdata, o_load_checksum;
    mem_cmd_t    o_mem_cmd;
    boot_phase_e o_phase;

    word_t stim [0:63];
    word_t mem [word_t];   // sparse memory model
    word_t wr_addr [$];    // every write seen, in order
    word_t wr_data [$];
    logic [3:0] wr_be [$];
    word_t rd_addr;
    logic  rd_pend;
    logic  corrupt_read;   // flips a bit in the next read
    int    lat_cnt;
    int    n_mismatch;
    int    n_timeout;

    mem_boot_top #(
        .ZERO_WORDS(ZERO_WORDS), .IMG_BASE(IMG_BASE),
        .IMG_WORDS(IMG_WORDS), .ADDR_MASK(ADDR_MASK)
    ) i_mem_boot_top (
        .clk(clk), .i_arst_n(i_arst_n), .i_calib_done(i_calib_done), .i_img(i_img),
        .i_cpu(i_cpu), .i_mem_busy(mem_busy), .i_mem_rdata(mem_rdata),
        .o_img_ready(o_img_ready), .o_cpu_busy(o_cpu_busy), .o_cpu_rdata(o_cpu_rdata),
        .o_mem_cmd(o_mem_cmd), .o_phase(o_phase), .o_boot_done(o_boot_done),
        .o_verify_ok(o_verify_ok), .o_load_checksum(o_load_checksum)
    );

    always #5 clk = ~clk;

    // memory takes a command while not busy, busy for 1 to 4 cycles
    always @(posedge clk) begin
        if (!i_arst_n) begin
            #1;
            mem_busy = 1'b0;
            rd_pend  = 1'b0;
            lat_cnt  = 0;
        end else if (!mem_busy && o_mem_cmd.op != OP_IDLE) begin
            if (o_mem_cmd.op == OP_WRITE) begin
                mem[o_mem_cmd.addr] = o_mem_cmd.wdata;
                wr_addr.push_back(o_mem_cmd.addr);
                wr_data.push_back(o_mem_cmd.wdata);
                wr_be.push_back(o_mem_cmd.be);
            end else begin
                rd_addr = o_mem_cmd.addr;
                rd_pend = 1'b1;
            end
            lat_cnt = $urandom_range(4, 1);
            #1 mem_busy = 1'b1;
        end else if (mem_busy) begin
            lat_cnt--;
            if (lat_cnt == 0) begin
                #1;
                mem_busy = 1'b0;  // read data valid with the falling busy
                if (rd_pend) begin
                    mem_rdata = mem.exists(rd_addr) ? mem[rd_addr] : rd_addr ^ 32'hC3C3_5A5A;
                    if (corrupt_read) begin
                        mem_rdata    = mem_rdata ^ 32'h0000_0100;
                        corrupt_read = 1'b0;
                    end
                    rd_pend = 1'b0;
                end
            end
        end
    end

    task automatic check(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d timeouts", n_mismatch, n_timeout);
        if (n_mismatch == 0 && n_timeout == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("Timeout: no %s within %0d cycles at %0t ns", what, TIMEOUT, $time);
        n_timeout++;
        finish_run();
    endtask

    function automatic logic probe(input int which);
        case (which)
            SIG_READY: probe = o_img_ready;
            SIG_DONE:  probe = o_boot_done;
            default:   probe = o_cpu_busy;
        endcase
    endfunction

    // returns on the falling edge where the signal has the level
    task automatic wait_for(input int which, input logic level, input string what);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (probe(which) !== level && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (probe(which) !== level) begin
            timed_out(what);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        i_arst_n     = 1'b0;
        i_calib_done = 1'b0;
        i_img        = '0;
        i_cpu        = '0;
        repeat (3) @(posedge clk);
        #1 i_arst_n = 1'b1;
    endtask

    task automatic send_word(input word_t data);
        int gap;
        gap = $urandom_range(2, 0);
        repeat (gap) @(posedge clk);  // valid gap
        @(posedge clk);
        #1;
        i_img.valid = 1'b1;
        i_img.data  = data;
        wait_for(SIG_READY, 1'b1, "image ready");
        @(posedge clk);  // word taken here
        #1 i_img.valid = 1'b0;
    endtask

    task automatic run_boot(input logic corrupt, input logic exp_ok);
        word_t sum;
        int    i;
        sum = '0;
        wr_addr.delete();
        wr_data.delete();
        wr_be.delete();
        apply_reset();
        corrupt_read = corrupt;
        repeat (4) begin
            @(negedge clk);
            check(o_phase, PH_CALIB, "phase before calibration");
            check(o_mem_cmd.op, OP_IDLE, "memory command before calibration");
            check(o_img_ready, 1'b0, "image ready before calibration");
            check(o_boot_done, 1'b0, "boot done before calibration");
            check(o_cpu_busy, 1'b1, "cpu busy before calibration");
        end
        @(posedge clk);
        #1 i_calib_done = 1'b1;
        for (i = 0; i < IMG_WORDS; i++) begin
            send_word(stim[i]);
            sum = sum + stim[i];
        end
        wait_for(SIG_DONE, 1'b1, "boot done");
        check(o_load_checksum, sum, "load checksum");
        check(o_verify_ok, exp_ok, "verify result");
        check(wr_addr.size(), ZERO_WORDS + IMG_WORDS, "number of boot writes");
        for (i = 0; i < ZERO_WORDS + IMG_WORDS && i < wr_addr.size(); i++) begin
            check(wr_be[i], 4'hF, "boot write byte enables");
            if (i < ZERO_WORDS) begin
                check(wr_addr[i], i * 4, "zero fill address");
                check(wr_data[i], '0, "zero fill data");
            end else begin
                check(wr_addr[i], IMG_BASE + (i - ZERO_WORDS) * 4, "image address");
                check(wr_data[i], stim[i - ZERO_WORDS], "image data");
            end
        end
    endtask

    // op 1 writes and expects the address seen at memory, op 2 reads
    task automatic cpu_access(input word_t op, input word_t addr, input word_t wdata,
                              input word_t exp);
        int n_wr;
        n_wr = wr_addr.size();
        @(posedge clk);
        #1;
        i_cpu.wr    = (op == 32'h1);
        i_cpu.rd    = (op == 32'h2);
        i_cpu.addr  = addr;
        i_cpu.wdata = wdata;
        i_cpu.be    = 4'hF;
        wait_for(SIG_CPU_BUSY, 1'b1, "cpu request accepted");
        @(posedge clk);
        #1;
        i_cpu.wr = 1'b0;
        i_cpu.rd = 1'b0;
        wait_for(SIG_CPU_BUSY, 1'b0, "end of cpu access");
        if (op == 32'h1) begin
            check(wr_addr.size(), n_wr + 1, "cpu write count");
            check(wr_addr[wr_addr.size() - 1], exp, "cpu write address at memory");
            check(wr_data[wr_data.size() - 1], wdata, "cpu write data at memory");
            check(wr_be[wr_be.size() - 1], 4'hF, "cpu write byte enables at memory");
        end else begin
            check(o_cpu_rdata, exp, "cpu read data");
        end
    endtask

    initial begin
        int k;
        clk          = 1'b0;
        i_arst_n     = 1'b0;
        i_calib_done = 1'b0;
        i_img        = '0;
        i_cpu        = '0;
        mem_busy     = 1'b0;
        mem_rdata    = '0;
        rd_pend      = 1'b0;
        corrupt_read = 1'b0;
        lat_cnt      = 0;
        n_mismatch   = 0;
        n_timeout    = 0;
        void'($urandom(32'ha40c));
        $readmemh("bench/mem_boot_stimulus.txt", stim);
        run_boot(1'b0, 1'b1);
        k = IMG_WORDS;
        while (k < 60 && (stim[k] == 32'h1 || stim[k] == 32'h2)) begin
            cpu_access(stim[k], stim[k + 1], stim[k + 2], stim[k + 3]);
            k = k + 4;
        end
        run_boot(1'b1, 1'b0);  // one readback word corrupted
        finish_run();
    end

endmodule

// File: bench/mem_boot_stimulus.txt
// first 8 values: image words, loaded from IMG_BASE upward
// then cpu operations: op (1 write, 2 read, f end), address, write data, expected
// a write expects the address seen at memory, a read expects the read data
3c0de001
8badf00d
ffffffff
00000001
12345678
9abcdef0
a5a5a5a5
00c0ffee
// cpu writes, the second one lands masked
1 00000010 cafe0001 00000010
1 000001f0 0badf00d 000000f0
1 00000044 12345678 00000044
// cpu reads
2 00000010 00000000 cafe0001
2 000000f0 00000000 0badf00d
2 00000044 00000000 12345678
2 000003f0 00000000 0badf00d
2 00000020 00000000 3c0de001
2 0000003c 00000000 00c0ffee
2 00000018 00000000 00000000
f 00000000 00000000 00000000

// File: verilog.f
verilog/meminit_pkg.sv
verilog/boot_sequencer.sv
verilog/zero_fill.sv
verilog/image_loader.sv
verilog/readback_verify.sv
verilog/mem_arbiter.sv
verilog/mem_boot_top.sv
bench/mem_boot_checker.sv
bench/tb_mem_boot.sv
